//--- fas_params.svh
////////////////////////////////////////
// Width and size macros for the FIR filter
// and the sample framer
////////////////////////////////////////
`ifndef FAS_PARAMS_SVH
`define FAS_PARAMS_SVH

////////////////////////////////////////
// Sample path
////////////////////////////////////////
`define FAS_SAMPLE_W   16   // Signed input and output samples

// Filter taps, fixed by the coefficient table
`define FAS_TAPS       32

////////////////////////////////////////
// Coefficients and accumulator
////////////////////////////////////////
`define FAS_COEF_W     20   // Signed coefficient word
`define FAS_COEF_FRAC  16   // Q16 fraction bits

// 16 x 20 product plus 5 guard bits for 32 terms
`define FAS_ACC_W      41

////////////////////////////////////////
// Framer
////////////////////////////////////////
`define FAS_FRAME_LEN  16   // Samples per frame for the transform stage

`endif

//--- fas_pkg.sv
////////////////////////////////////////
// Sample, coefficient, accumulator, tap and
// frame types, plus the FIR coefficient table
////////////////////////////////////////
`include "fas_params.svh"

package fas_pkg;

  ////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;  // Audio sample
  typedef logic signed [`FAS_COEF_W-1:0]   coef_t;    // Q16 coefficient
  typedef logic signed [`FAS_ACC_W-1:0]    acc_t;     // Sum of products

  // Index 0 is the newest sample in the line
  typedef sample_t [`FAS_TAPS-1:0]      tap_array_t;

  // Index 0 is the oldest sample of the frame
  typedef sample_t [`FAS_FRAME_LEN-1:0] frame_t;

  ////////////////////////////////////////
  // Low-pass coefficients
  ////////////////////////////////////////
  // Entry k weights the sample that is k samples old
  // Table is symmetric about the 15/16 midpoint
  localparam coef_t FIR_COEF [`FAS_TAPS] = '{
    20'hFFF9E, 20'hFFF86,   // Outer side lobe
    20'hFFFA7, 20'h0003B,
    20'h0014B, 20'h0024A,
    20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA,   // First negative lobe
    20'hFF74E, 20'hFFD74,
    20'h00B1A, 20'h01DAC,   // Rising edge of main lobe
    20'h02F9E, 20'h03AA9,   // Peak near 0.229
    20'h03AA9, 20'h02F9E,
    20'h01DAC, 20'h00B1A,
    20'hFFD74, 20'hFF74E,
    20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222,
    20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7,
    20'hFFF86, 20'hFFF9E    // Mirror of entries 0 and 1
  };

endpackage

//--- fir_delay_line.sv
////////////////////////////////////////
// FIR input delay line of the last 32 samples
// with run fill counter and tap valid
////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_params.svh"

module fir_delay_line import fas_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       data_valid,  // Sample accepted at this edge
  input  sample_t    data,
  output tap_array_t taps,        // Index 0 newest
  output logic       tap_valid    // Line full for the current run
);

  // Samples seen in the current run saturate at the tap count
  logic [$clog2(`FAS_TAPS+1)-1:0] fill_cnt;
  logic                           fill_done;  // Line full after this sample

  // 31 already held means this sample completes the window
  assign fill_done = (fill_cnt >= `FAS_TAPS - 1);

  ////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      taps <= '0;
    end else if (data_valid) begin
      // New sample enters slot 0 and the oldest falls off the top
      taps <= {taps[`FAS_TAPS-2:0], data};
    end
  end

  ////////////////////////////////////////
  // Fill counter and valid
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt  <= '0;
      tap_valid <= 1'b0;
    end else if (!data_valid) begin
      // Gap ends the run and the window must refill
      fill_cnt  <= '0;
      tap_valid <= 1'b0;
    end else begin
      if (fill_cnt != `FAS_TAPS) begin
        fill_cnt <= fill_cnt + 1'b1;         // Hold at 32 once full
      end
      tap_valid <= fill_done;                // One cycle after the accepting edge
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Counter must saturate and never run past the window size
  a_fill_bound : assert property (
    @(posedge clk) disable iff (rst)
    fill_cnt <= `FAS_TAPS
  );

endmodule

//--- fir_mac.sv
////////////////////////////////////////
// FIR multiply-accumulate over 32 taps
// Q16 rounding to a registered 16-bit output
////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_params.svh"

module fir_mac import fas_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  tap_array_t taps,       // From delay line with index 0 newest
  input  logic       tap_valid,  // Window full and freshly shifted
  output sample_t    fir_d,      // Filtered sample
  output logic       fir_valid
);

  acc_t    acc;        // Full precision sum of all products
  logic    acc_neg;    // Sign of the sum
  sample_t acc_trunc;  // Sign plus integer bits 30..16
  sample_t fir_next;   // Rounded result

  ////////////////////////////////////////
  // Sum of products
  ////////////////////////////////////////
  // Signed operands widen each product to acc_t before the add
  always_comb begin
    acc = '0;
    for (int k = 0; k < `FAS_TAPS; k++) begin
      acc = acc + $signed(taps[k]) * FIR_COEF[k];  // Entry k weights sample k old
    end
  end

  ////////////////////////////////////////
  // Q16 to 16-bit rounding
  ////////////////////////////////////////
  assign acc_neg = acc[`FAS_ACC_W-1];

  // Drop the 16 fraction bits and keep 15 integer bits under the sign
  assign acc_trunc = {acc_neg, acc[`FAS_COEF_FRAC+`FAS_SAMPLE_W-2:`FAS_COEF_FRAC]};

  // Negative sums get one added back
  // Floor then +1 pulls negative results toward zero
  assign fir_next = acc_trunc + {{(`FAS_SAMPLE_W-1){1'b0}}, acc_neg};

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_d     <= '0;
      fir_valid <= 1'b0;
    end else begin
      fir_valid <= tap_valid;        // Same cycle as the data capture
      if (tap_valid) begin
        fir_d <= fir_next;           // Hold last result between runs
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Output strobe is exactly one stage behind the tap window
  a_valid_follows_taps : assert property (
    @(posedge clk) disable iff (rst)
    fir_valid |-> $past(tap_valid)
  );

endmodule

//--- sample_framer.sv
////////////////////////////////////////
// Serial to parallel framer
// Gathers 16 filtered samples into one frame
////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_params.svh"

module sample_framer import fas_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  sample_t fir_d,        // Filtered sample
  input  logic    fir_valid,
  output frame_t  frame_d,      // Index 0 oldest and held until next frame
  output logic    frame_valid   // One-cycle pulse per complete frame
);

  frame_t frame_buf;    // Slots filled so far in this frame
  frame_t frame_next;   // Buffer with the incoming sample placed
  logic [$clog2(`FAS_FRAME_LEN)-1:0] idx;  // Next slot to write
  logic last_slot;      // Incoming sample completes the frame

  ////////////////////////////////////////
  // Slot write
  ////////////////////////////////////////
  always_comb begin
    frame_next      = frame_buf;
    frame_next[idx] = fir_d;     // Oldest sample lands in slot 0
  end

  assign last_slot = (idx == `FAS_FRAME_LEN - 1);

  ////////////////////////////////////////
  // Index, buffer and frame output
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_buf   <= '0;
      frame_d     <= '0;
      idx         <= '0;
      frame_valid <= 1'b0;
    end else if (fir_valid) begin
      frame_buf   <= frame_next;
      idx         <= idx + 1'b1;     // Wraps to 0 after slot 15
      frame_valid <= last_slot;
      if (last_slot) begin
        frame_d <= frame_next;       // Publish the whole frame at once
      end
    end else begin
      // Gap in the filtered stream drops any partial frame
      idx         <= '0;
      frame_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Frames are at least 16 samples apart
  a_single_pulse : assert property (
    @(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid
  );

endmodule

//--- fas_top.sv
////////////////////////////////////////
// Filter and framer top level
// Delay line, MAC and framer in series
////////////////////////////////////////
`timescale 1ns/1ps

module fas_top import fas_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,   // No ready, every valid sample is taken
  input  sample_t data,
  output logic    fir_valid,    // 2 cycles after the accepting edge
  output sample_t fir_d,
  output logic    frame_valid,  // 3 cycles after the frame's last sample
  output frame_t  frame_d
);

  tap_array_t taps;       // Delay line window
  logic       tap_valid;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////
  fir_delay_line u_delay (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .taps       (taps),
    .tap_valid  (tap_valid)
  );

  ////////////////////////////////////////
  // Filter arithmetic
  ////////////////////////////////////////
  fir_mac u_mac (
    .clk       (clk),
    .rst       (rst),
    .taps      (taps),
    .tap_valid (tap_valid),
    .fir_d     (fir_d),       // Also leaves the block directly
    .fir_valid (fir_valid)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////
  sample_framer u_framer (
    .clk         (clk),
    .rst         (rst),
    .fir_d       (fir_d),
    .fir_valid   (fir_valid),
    .frame_d     (frame_d),
    .frame_valid (frame_valid)
  );

endmodule

//--- tb_fas.sv
////////////////////////////////////////
// Testbench for the filter and framer
// Stimulus table, LCG, reference model,
// compare tasks and cycle limit
////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_params.svh"

module tb_fas import fas_pkg::*; ();

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////
  localparam int          N_ROWS    = 8;
  localparam int          RST_CYC   = 8;      // Reset length in clocks
  localparam int          IDLE_CYC  = 12;     // Quiet period before the first run
  localparam logic [31:0] LCG_SEED  = 32'd97;
  localparam int          K_IMPULSE = 0;      // 31 zeros then AMP then zeros
  localparam int          K_CONST   = 1;      // AMP on every sample
  localparam int          K_RANDOM  = 2;      // LCG samples

  // Columns are run length, gap after it, pattern and amplitude
  // followed by expected filter outputs and frames of the run
  localparam int RUN_LEN    [N_ROWS] = '{63, 40, 80, 48, 31, 100, 63, 33};
  localparam int GAP_LEN    [N_ROWS] = '{ 3,  1,  1,  2,  4,   5,  1,  3};
  localparam int KIND       [N_ROWS] = '{K_IMPULSE, K_CONST, K_RANDOM, K_CONST,
                                         K_RANDOM, K_RANDOM, K_IMPULSE, K_RANDOM};
  localparam int AMP        [N_ROWS] = '{16384, 32767, 0, -32768, 0, 0, -16384, 0};
  localparam int EXP_OUTS   [N_ROWS] = '{32, 9, 49, 17, 0, 69, 32, 2};
  localparam int EXP_FRAMES [N_ROWS] = '{ 2, 0,  3,  1, 0,  4,  2, 0};

  logic    clk = 1'b0;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame_d;

  // Reference model state
  tap_array_t  hist;            // Model window with index 0 newest
  int          fill;            // Samples of the current run with saturation
  frame_t      frm_acc;         // Frame being gathered
  int          fidx;            // Next frame slot
  sample_t     exp_fir_q [$];   // Expected filter outputs
  int          fir_due_q [$];   // Check cycle of each one
  frame_t      exp_frame_q [$];
  int          frame_due_q [$];
  int          ncyc;            // Falling edges since reset release

  int          value_errs;
  int          hs_errs;         // Missing or extra valids
  int          count_errs;
  int          fir_seen;
  int          frames_seen;
  int          cyc_cnt;
  int          cycle_limit;
  logic [31:0] lcg_state;

  always #50 clk = ~clk;        // 100 ns period

  fas_top DUT (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] next_lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Sign bit over bits 30..16 plus one when negative
  function automatic sample_t round_q16(input acc_t a);
    acc_t    sh;
    sample_t r;
    sh = a >>> `FAS_COEF_FRAC;
    r = sh[`FAS_SAMPLE_W-1:0];
    r[`FAS_SAMPLE_W-1] = a[`FAS_ACC_W-1];   // Sign from the full sum
    if (a[`FAS_ACC_W-1]) begin
      r = r + 16'sd1;
    end
    return r;
  endfunction

  function automatic sample_t filter_ref(input tap_array_t h);
    acc_t a;
    a = '0;
    for (int k = 0; k < `FAS_TAPS; k++) begin
      a = a + acc_t'(h[k]) * acc_t'(FIR_COEF[k]);  // Sample k old times entry k
    end
    return round_q16(a);
  endfunction

  function automatic int total_cycles();
    int n;
    n = RST_CYC + IDLE_CYC + 50;
    for (int r = 0; r < N_ROWS; r++) begin
      n = n + RUN_LEN[r] + GAP_LEN[r];
    end
    return n;
  endfunction

  task automatic compare_sample(input string name, input sample_t exp_s, input sample_t act_s);
    if (act_s !== exp_s) begin
      value_errs++;
      $display("[ERROR] time %0t %s expected %0d actual %0d", $time, name, exp_s, act_s);
    end
  endtask

  task automatic verify_frame(input string name, input frame_t exp_f, input frame_t act_f);
    if (act_f !== exp_f) begin
      value_errs++;
      $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp_f, act_f);
    end
  endtask

  ////////////////////////////////////////
  // Reference model and output checks
  ////////////////////////////////////////
  // Falling edge sampling while DUT outputs and driven inputs are stable
  always @(negedge clk) begin : model_check
    logic    exp_v;
    sample_t exp_s;
    logic    frm_v;
    frame_t  exp_f;
    if (!rst) begin
      exp_v = 1'b0;
      exp_s = '0;
      if (fir_due_q.size() > 0 && fir_due_q[0] == ncyc) begin
        exp_v = 1'b1;
        exp_s = exp_fir_q.pop_front();
        void'(fir_due_q.pop_front());
      end
      if (fir_valid) begin
        fir_seen++;
      end
      if (exp_v && !fir_valid) begin
        hs_errs++;
        $display("Missing fir_valid at time %0t for an accepted sample", $time);
      end else if (!exp_v && fir_valid) begin
        hs_errs++;
        $display("Unexpected fir_valid at time %0t with no full window", $time);
      end else if (exp_v) begin
        compare_sample("fir_d", exp_s, fir_d);
      end

      // Framer rule on the expected valid stream
      if (exp_v) begin
        frm_acc[fidx] = exp_s;                   // Oldest in slot 0
        if (fidx == `FAS_FRAME_LEN - 1) begin
          exp_frame_q.push_back(frm_acc);
          frame_due_q.push_back(ncyc + 1);       // One cycle after the 16th output
          fidx = 0;
        end else begin
          fidx++;
        end
      end else begin
        fidx = 0;                                // Gap drops the partial frame
      end

      frm_v = 1'b0;
      exp_f = '0;
      if (frame_due_q.size() > 0 && frame_due_q[0] == ncyc) begin
        frm_v = 1'b1;
        exp_f = exp_frame_q.pop_front();
        void'(frame_due_q.pop_front());
      end
      if (frame_valid) begin
        frames_seen++;
      end
      if (frm_v && !frame_valid) begin
        hs_errs++;
        $display("Missing frame_valid at time %0t after 16 filter outputs", $time);
      end else if (!frm_v && frame_valid) begin
        hs_errs++;
        $display("Unexpected frame_valid at time %0t", $time);
      end else if (frm_v) begin
        verify_frame("frame_d", exp_f, frame_d);
      end

      // Input side sample is taken at the next rising edge
      if (data_valid) begin
        hist = {hist[`FAS_TAPS-2:0], data};
        if (fill < `FAS_TAPS) begin
          fill++;
        end
        if (fill == `FAS_TAPS) begin
          exp_fir_q.push_back(filter_ref(hist));
          fir_due_q.push_back(ncyc + 2);         // Visible 2 clocks after acceptance
        end
      end else begin
        fill = 0;                                // Run ends and the window refills
      end
      ncyc++;
    end
  end

  ////////////////////////////////////////
  // Cycle limit
  ////////////////////////////////////////
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, expected outputs never arrived", cyc_cnt);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    sample_t smp;
    int      exp_outs;
    int      exp_frames;
    rst         = 1'b1;
    data_valid  = 1'b0;
    data        = '0;
    hist        = '0;
    frm_acc     = '0;
    fill        = 0;
    fidx        = 0;
    ncyc        = 0;
    value_errs  = 0;
    hs_errs     = 0;
    count_errs  = 0;
    fir_seen    = 0;
    frames_seen = 0;
    cyc_cnt     = 0;
    exp_outs    = 0;
    exp_frames  = 0;
    lcg_state   = LCG_SEED;
    cycle_limit = total_cycles();

    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    repeat (IDLE_CYC) @(posedge clk);            // Outputs must stay quiet here

    for (int r = 0; r < N_ROWS; r++) begin
      exp_outs   = exp_outs + EXP_OUTS[r];
      exp_frames = exp_frames + EXP_FRAMES[r];
      for (int i = 0; i < RUN_LEN[r]; i++) begin
        case (KIND[r])
          K_IMPULSE: smp = (i == `FAS_TAPS - 1) ? sample_t'(AMP[r]) : '0;
          K_CONST:   smp = sample_t'(AMP[r]);
          default: begin
            lcg_state = next_lcg(lcg_state);
            smp = sample_t'(lcg_state[30:15]);   // Upper bits are the better ones
          end
        endcase
        @(posedge clk);
        data_valid <= 1'b1;
        data       <= smp;
      end
      for (int g = 0; g < GAP_LEN[r]; g++) begin
        @(posedge clk);
        data_valid <= 1'b0;
        data       <= '0;
      end
    end

    // Drain until every queued expectation has come due
    while (fir_due_q.size() > 0 || frame_due_q.size() > 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    if (fir_seen != exp_outs) begin
      count_errs++;
      $display("Filter gave %0d outputs where the table expects %0d", fir_seen, exp_outs);
    end
    if (frames_seen != exp_frames) begin
      count_errs++;
      $display("Framer gave %0d frames where the table expects %0d", frames_seen, exp_frames);
    end

    $display("Errors: value %0d, handshake %0d, count %0d", value_errs, hs_errs, count_errs);
    if (value_errs + hs_errs + count_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
fas_pkg.sv
fir_delay_line.sv
fir_mac.sv
sample_framer.sv
fas_top.sv
tb_fas.sv

//--- Makefile
# Verilator build for the filter and framer

TOP = tb_fas
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

# RTL top level first, then the testbench on top of it
lint:
	verilator --lint-only --timing --top-module fas_top -f vlog.f
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

# Pass only when the pass line shows up in the run output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f vlog.f
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ)
